// ==== dv/copro_tb.sv ====
`timescale 1ns/1ps

module copro_tb;

  localparam int RandIssues = 200;
  localparam int MaskIssues = 40;
  localparam int NumIssues  = RandIssues + MaskIssues + 40;

  logic                       clk_i;
  logic                       arst_n_i;
  logic                       issue_valid_i;
  logic                       issue_ready_o;
  logic [31:0]                issue_instr_i;
  logic [copro_pkg::ID_W-1:0] issue_id_i;
  logic [copro_pkg::XLEN-1:0] issue_rs1_i;
  logic [copro_pkg::XLEN-1:0] issue_rs2_i;
  logic                       issue_accept_o;
  logic                       result_valid_o;
  logic                       result_ready_i;
  logic [copro_pkg::ID_W-1:0] result_id_o;
  logic [4:0]                 result_rd_o;
  logic [copro_pkg::XLEN-1:0] result_data_o;
  logic                       cfg_we_i;
  logic [3:0]                 cfg_en_i;
  logic [3:0]                 cfg_en_o;
  logic [15:0]                acc_count_o;

  copro_pkg::result_t got_res;
  copro_pkg::result_t held_res;
  copro_pkg::result_t exp_res;
  copro_pkg::result_t exp_q[$];
  logic [3:0]         model_mask;
  logic [31:0]        exp_data;
  bit                 exp_acc;
  bit                 held;
  bit                 stalled;
  int                 handshakes;
  int                 accepts;
  int                 tries;

  copro_top #(
    .FifoDepth ( 4 )
  ) UUT (
    .clk_i          ( clk_i          ),
    .arst_n_i       ( arst_n_i       ),
    .issue_valid_i  ( issue_valid_i  ),
    .issue_ready_o  ( issue_ready_o  ),
    .issue_instr_i  ( issue_instr_i  ),
    .issue_id_i     ( issue_id_i     ),
    .issue_rs1_i    ( issue_rs1_i    ),
    .issue_rs2_i    ( issue_rs2_i    ),
    .issue_accept_o ( issue_accept_o ),
    .result_valid_o ( result_valid_o ),
    .result_ready_i ( result_ready_i ),
    .result_id_o    ( result_id_o    ),
    .result_rd_o    ( result_rd_o    ),
    .result_data_o  ( result_data_o  ),
    .cfg_we_i       ( cfg_we_i       ),
    .cfg_en_i       ( cfg_en_i       ),
    .cfg_en_o       ( cfg_en_o       ),
    .acc_count_o    ( acc_count_o    )
  );

  assign got_res = {result_id_o, result_rd_o, result_data_o};

  always #20 clk_i = ~clk_i;

  task automatic report_failure(input string msg);
    $display("error at %0t: %s", $time, msg);
    $display("TEST FAILED");
    $fatal(1);
  endtask

  task automatic check_accept(input bit got, input bit exp, input string msg);
    if (got !== exp) begin
      $display("mismatch at %0t: %s got %0b expected %0b", $time, msg, got, exp);
      $display("TEST FAILED");
      $fatal(1);
    end
  endtask

  task automatic check_result(input copro_pkg::result_t got, input copro_pkg::result_t exp,
                              input string msg);
    if (got !== exp) begin
      $display("mismatch at %0t: %s got id %h rd %h data %h expected id %h rd %h data %h",
               $time, msg, got.id, got.rd, got.data, exp.id, exp.rd, exp.data);
      $display("TEST FAILED");
      $fatal(1);
    end
  endtask

  task automatic check_count(input logic [15:0] got, input logic [15:0] exp, input string msg);
    if (got !== exp) begin
      $display("mismatch at %0t: %s got %0d expected %0d", $time, msg, got, exp);
      $display("TEST FAILED");
      $fatal(1);
    end
  endtask

  task automatic check_mask(input logic [3:0] got, input logic [3:0] exp, input string msg);
    if (got !== exp) begin
      $display("mismatch at %0t: %s got %b expected %b", $time, msg, got, exp);
      $display("TEST FAILED");
      $fatal(1);
    end
  endtask

  // Mostly legal encodings, some with a bad funct field, some fully random
  function automatic logic [31:0] rand_instr();
    logic [31:0] w;
    int          kind;
    w    = $urandom;
    kind = $urandom_range(0, 9);
    if (kind < 6) begin
      w[6:0]   = copro_pkg::OPC_CUSTOM0;
      w[14:12] = 3'($urandom_range(0, 3));
      w[31:25] = ($urandom_range(0, 7) == 0) ? w[31:25] : 7'd0;
    end else if (kind < 9) begin
      w[6:0]   = copro_pkg::OPC_CUSTOM1;
      w[14:12] = ($urandom_range(0, 5) == 0) ? w[14:12] : 3'd0;
    end
    return w;
  endfunction

  // Reference decode and execute, returns the accept decision
  function automatic bit model_exec(input logic [31:0] w, input logic [31:0] a,
                                    input logic [31:0] b, input logic [3:0] mask,
                                    output logic [31:0] data);
    logic [1:0] op;
    bit         legal;
    op    = 2'd0;
    legal = 1'b0;
    data  = '0;
    if (w[6:0] == copro_pkg::OPC_CUSTOM0 && w[31:25] == 7'd0 && w[14:12] <= 3'd2) begin
      legal = 1'b1;
      op    = w[13:12];
    end else if (w[6:0] == copro_pkg::OPC_CUSTOM1 && w[14:12] == 3'd0) begin
      legal = 1'b1;
      op    = 2'd3;
    end
    case (op)
      2'd0:    data = a + b;
      2'd1:    data = a - b;
      2'd2:    data = a * b;
      default: data = a + {{20{w[31]}}, w[31:20]};
    endcase
    return legal && mask[op];
  endfunction

  // Payload is held while an issue waits for ready
  task automatic drive_cycle(input int valid_pct, input int ready_pct, input bit we,
                             input logic [3:0] mask);
    @(posedge clk_i);
    #2;
    if (!stalled) begin
      issue_valid_i = ($urandom_range(0, 99) < valid_pct);
      issue_instr_i = rand_instr();
      issue_id_i    = 4'($urandom);
      issue_rs1_i   = $urandom;
      issue_rs2_i   = $urandom;
    end
    result_ready_i = ($urandom_range(0, 99) < ready_pct);
    cfg_we_i       = we;
    cfg_en_i       = mask;
  endtask

  task automatic write_mask(input logic [3:0] mask);
    drive_cycle(0, 100, 1'b1, mask);
    drive_cycle(0, 100, 1'b0, 4'd0);
    @(negedge clk_i);
    check_mask(cfg_en_o, mask, "cfg_en_o readback");
  endtask

  // Sampled mid-cycle, where every input and output is settled
  always @(negedge clk_i) begin
    if (arst_n_i) begin
      if (held) begin
        if (!result_valid_o) begin
          report_failure("result_valid_o dropped before its transfer");
        end
        check_result(got_res, held_res, "result payload under back-pressure");
      end
      if (result_valid_o && result_ready_i) begin
        if (exp_q.size() == 0) begin
          report_failure("result delivered that the model never expected");
        end else begin
          check_result(got_res, exp_q.pop_front(), "result in issue order");
        end
      end
      held     = result_valid_o && !result_ready_i;
      held_res = got_res;
      if (issue_valid_i && issue_ready_o) begin
        exp_acc = model_exec(issue_instr_i, issue_rs1_i, issue_rs2_i, model_mask, exp_data);
        check_accept(issue_accept_o, exp_acc, "issue_accept_o");
        if (exp_acc) begin
          exp_res.id   = issue_id_i;
          exp_res.rd   = issue_instr_i[11:7];
          exp_res.data = exp_data;
          exp_q.push_back(exp_res);
          accepts++;
        end
        handshakes++;
      end
      stalled = issue_valid_i && !issue_ready_o;
      // The new mask applies from the next edge on
      if (cfg_we_i) begin
        model_mask = cfg_en_i;
      end
    end
  end

  initial begin
    repeat (NumIssues * 20 + 200) @(posedge clk_i);
    $display("error: watchdog expired before the test sequence completed");
    $display("TEST FAILED");
    $fatal(1);
  end

  initial begin
    void'($urandom(26));
    clk_i          = 1'b0;
    arst_n_i       = 1'b0;
    issue_valid_i  = 1'b0;
    issue_instr_i  = '0;
    issue_id_i     = '0;
    issue_rs1_i    = '0;
    issue_rs2_i    = '0;
    result_ready_i = 1'b0;
    cfg_we_i       = 1'b0;
    cfg_en_i       = '0;
    model_mask     = 4'hf;
    repeat (3) @(posedge clk_i);
    #2;
    arst_n_i = 1'b1;
    @(negedge clk_i);
    check_accept(issue_ready_o, 1'b1, "issue_ready_o after reset");
    check_accept(result_valid_o, 1'b0, "result_valid_o after reset");
    check_count(acc_count_o, 16'd0, "acc_count_o after reset");
    check_mask(cfg_en_o, 4'hf, "cfg_en_o after reset");

    // Random traffic with occasional mask rewrites
    while (handshakes < RandIssues) begin
      drive_cycle(70, 70, $urandom_range(0, 19) == 0, 4'($urandom));
    end

    // Multiply disabled, then everything enabled again
    write_mask(4'b1011);
    while (handshakes < RandIssues + MaskIssues) begin
      drive_cycle(80, 70, 1'b0, 4'd0);
    end
    write_mask(4'b1111);

    // Hold the result channel until issue backs up
    tries = 0;
    while (issue_ready_o && tries < 40) begin
      drive_cycle(100, 0, 1'b0, 4'd0);
      @(negedge clk_i);
      tries++;
    end
    if (issue_ready_o) begin
      report_failure("issue_ready_o stayed high while results were blocked");
    end
    repeat (5) drive_cycle(100, 0, 1'b0, 4'd0);

    // Drain on the DUT's own valid, then let the pipe run empty
    while (result_valid_o || stalled) begin
      drive_cycle(0, 100, 1'b0, 4'd0);
    end
    repeat (4) drive_cycle(0, 100, 1'b0, 4'd0);
    @(negedge clk_i);
    check_count(acc_count_o, 16'(accepts), "acc_count_o after drain");
    if (exp_q.size() != 0) begin
      report_failure("expected results are still outstanding after the drain");
    end else begin
      $display("TEST PASSED");
      $finish;
    end
  end

endmodule

// ==== files.f ====
src/copro_pkg.sv
src/copro_op_if.sv
src/copro_cfg_regs.sv
src/copro_decoder.sv
src/copro_exec.sv
src/copro_result_fifo.sv
src/copro_top.sv
dv/copro_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
set -e
cd "$(dirname "$0")"
verilator --binary --timing --assert -f files.f --top-module copro_tb
out=$(./obj_dir/Vcopro_tb 2>&1) || true
echo "$out"
if echo "$out" | grep -q "^TEST PASSED$"; then
  exit 0
else
  exit 1
fi

// ==== src/copro_cfg_regs.sv ====
`timescale 1ns/1ps

module copro_cfg_regs (
  input  logic        clk_i,
  input  logic        arst_n_i,
  input  logic        cfg_we_i,
  input  logic [3:0]  cfg_en_i,
  input  logic        accept_i,
  output logic [3:0]  op_en_o,
  output logic [15:0] acc_count_o
);

  // Operation enable mask, everything on out of reset
  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      op_en_o <= '1;
    end else if (cfg_we_i) begin
      op_en_o <= cfg_en_i;
    end
  end

  // Accepted instruction counter, wraps at 16 bits
  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      acc_count_o <= '0;
    end else if (accept_i) begin
      acc_count_o <= acc_count_o + 16'd1;
    end
  end

endmodule

// ==== src/copro_decoder.sv ====
`timescale 1ns/1ps

module copro_decoder (
  input  logic                       issue_valid_i,
  input  logic [31:0]                issue_instr_i,
  input  logic [copro_pkg::ID_W-1:0] issue_id_i,
  input  logic [copro_pkg::XLEN-1:0] issue_rs1_i,
  input  logic [copro_pkg::XLEN-1:0] issue_rs2_i,
  output logic                       issue_ready_o,
  output logic                       issue_accept_o,
  input  logic [3:0]                 op_en_i,
  output logic                       accept_o,
  copro_op_if.decoder                op_if
);

  copro_pkg::instr_u           instr;
  copro_pkg::op_e              dec_op;
  logic                        legal;
  logic [copro_pkg::XLEN-1:0]  dec_opb;

  assign instr = issue_instr_i;

  always_comb begin
    legal   = 1'b0;
    dec_op  = copro_pkg::OP_ADD;
    dec_opb = issue_rs2_i;
    if (instr.r.opcode == copro_pkg::OPC_CUSTOM0 && instr.r.funct7 == 7'd0) begin
      // R-type, funct3 selects the operation
      case (instr.r.funct3)
        3'd0: begin
          legal  = 1'b1;
          dec_op = copro_pkg::OP_ADD;
        end
        3'd1: begin
          legal  = 1'b1;
          dec_op = copro_pkg::OP_SUB;
        end
        3'd2: begin
          legal  = 1'b1;
          dec_op = copro_pkg::OP_MUL;
        end
        default: legal = 1'b0;
      endcase
    end else if (instr.i.opcode == copro_pkg::OPC_CUSTOM1 && instr.i.funct3 == 3'd0) begin
      // I-type, immediate replaces rs2
      legal   = 1'b1;
      dec_op  = copro_pkg::OP_ADDI;
      dec_opb = {{(copro_pkg::XLEN-12){instr.i.imm12[11]}}, instr.i.imm12};
    end
  end

  // Mask is checked at issue time only
  assign issue_accept_o = legal && op_en_i[dec_op];

  // Rejected words still complete the handshake, so ready follows the pipe
  assign issue_ready_o = op_if.op_ready;
  assign accept_o      = issue_valid_i && issue_ready_o && issue_accept_o;

  assign op_if.op_valid = issue_valid_i && issue_accept_o;
  assign op_if.op       = dec_op;
  assign op_if.id       = issue_id_i;
  assign op_if.rd       = instr.r.rd;
  assign op_if.opa      = issue_rs1_i;
  assign op_if.opb      = dec_opb;

endmodule

// ==== src/copro_exec.sv ====
`timescale 1ns/1ps

module copro_exec (
  input  logic               clk_i,
  input  logic               arst_n_i,
  copro_op_if.exec           op_if,
  output logic               res_valid_o,
  input  logic               res_ready_i,
  output copro_pkg::result_t res_o
);

  logic                        s1_valid;
  copro_pkg::op_e              s1_op;
  logic [copro_pkg::ID_W-1:0]  s1_id;
  logic [4:0]                  s1_rd;
  logic [copro_pkg::XLEN-1:0]  s1_opa;
  logic [copro_pkg::XLEN-1:0]  s1_opb;
  logic [copro_pkg::XLEN-1:0]  alu;
  logic                        s1_ready;
  logic                        s2_ready;

  // A stage moves when the one after it is empty or draining
  assign s2_ready       = !res_valid_o || res_ready_i;
  assign s1_ready       = !s1_valid || s2_ready;
  assign op_if.op_ready = s1_ready;

  // Stage 1 valid
  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      s1_valid <= 1'b0;
    end else if (s1_ready) begin
      s1_valid <= op_if.op_valid;
    end
  end

  // Stage 1 operands
  always_ff @(posedge clk_i) begin
    if (op_if.op_valid && s1_ready) begin
      s1_op  <= op_if.op;
      s1_id  <= op_if.id;
      s1_rd  <= op_if.rd;
      s1_opa <= op_if.opa;
      s1_opb <= op_if.opb;
    end
  end

  always_comb begin
    case (s1_op)
      copro_pkg::OP_ADD:  alu = s1_opa + s1_opb;
      copro_pkg::OP_SUB:  alu = s1_opa - s1_opb;
      // Only the low half of the product is kept
      copro_pkg::OP_MUL:  alu = s1_opa * s1_opb;
      copro_pkg::OP_ADDI: alu = s1_opa + s1_opb;
      default:            alu = '0;
    endcase
  end

  // Stage 2 valid
  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      res_valid_o <= 1'b0;
    end else if (s2_ready) begin
      res_valid_o <= s1_valid;
    end
  end

  // Stage 2 result
  always_ff @(posedge clk_i) begin
    if (s1_valid && s2_ready) begin
      res_o.id   <= s1_id;
      res_o.rd   <= s1_rd;
      res_o.data <= alu;
    end
  end

  // Result held while the FIFO pushes back
  a_res_stable: assert property (@(posedge clk_i) disable iff (!arst_n_i)
    res_valid_o && !res_ready_i |=> res_valid_o && $stable(res_o));

endmodule

// ==== src/copro_op_if.sv ====
`timescale 1ns/1ps

interface copro_op_if;

  logic                        op_valid;
  logic                        op_ready;
  copro_pkg::op_e              op;
  logic [copro_pkg::ID_W-1:0]  id;
  logic [4:0]                  rd;
  logic [copro_pkg::XLEN-1:0]  opa;
  logic [copro_pkg::XLEN-1:0]  opb;

  // Decoder side offers the operation
  modport decoder (
    output op_valid, op, id, rd, opa, opb,
    input  op_ready
  );

  // Execute side takes it when it has room
  modport exec (
    input  op_valid, op, id, rd, opa, opb,
    output op_ready
  );

endinterface

// ==== src/copro_pkg.sv ====
package copro_pkg;

  // Datapath and transaction id widths
  localparam int XLEN = 32;
  localparam int ID_W = 4;

  // Major opcodes reserved for custom extensions
  localparam logic [6:0] OPC_CUSTOM0 = 7'b0001011;
  localparam logic [6:0] OPC_CUSTOM1 = 7'b0101011;

  // Each value doubles as its bit position in the enable mask
  typedef enum logic [1:0] {
    OP_ADD  = 2'd0,
    OP_SUB  = 2'd1,
    OP_MUL  = 2'd2,
    OP_ADDI = 2'd3
  } op_e;

  typedef struct packed {
    logic [6:0] funct7;
    logic [4:0] rs2;
    logic [4:0] rs1;
    logic [2:0] funct3;
    logic [4:0] rd;
    logic [6:0] opcode;
  } r_fmt_t;

  typedef struct packed {
    logic [11:0] imm12;
    logic [4:0]  rs1;
    logic [2:0]  funct3;
    logic [4:0]  rd;
    logic [6:0]  opcode;
  } i_fmt_t;

  // Same instruction word seen as either format
  typedef union packed {
    r_fmt_t r;
    i_fmt_t i;
  } instr_u;

  // Write-back payload returned to the core
  typedef struct packed {
    logic [ID_W-1:0] id;
    logic [4:0]      rd;
    logic [XLEN-1:0] data;
  } result_t;

endpackage

// ==== src/copro_result_fifo.sv ====
`timescale 1ns/1ps

module copro_result_fifo #(
  parameter int FifoDepth = 4
) (
  input  logic               clk_i,
  input  logic               arst_n_i,
  input  logic               in_valid_i,
  output logic               in_ready_o,
  input  copro_pkg::result_t in_data_i,
  output logic               out_valid_o,
  input  logic               out_ready_i,
  output copro_pkg::result_t out_data_o
);

  localparam int PtrW = (FifoDepth > 1) ? $clog2(FifoDepth) : 1;
  localparam logic [PtrW:0]   Full    = (PtrW+1)'(FifoDepth);
  localparam logic [PtrW-1:0] LastPtr = PtrW'(FifoDepth - 1);

  copro_pkg::result_t mem [FifoDepth];
  logic [PtrW-1:0]    wr_ptr;
  logic [PtrW-1:0]    rd_ptr;
  logic [PtrW:0]      count;
  logic               push;
  logic               pop;

  assign in_ready_o  = (count != Full);
  assign out_valid_o = (count != '0);
  assign out_data_o  = mem[rd_ptr];
  assign push        = in_valid_i && in_ready_o;
  assign pop         = out_valid_o && out_ready_i;

  always_ff @(posedge clk_i) begin
    if (push) begin
      mem[wr_ptr] <= in_data_i;
    end
  end

  // Pointers wrap at the depth, which need not be a power of two
  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (push) begin
        wr_ptr <= (wr_ptr == LastPtr) ? '0 : wr_ptr + 1'b1;
      end
      if (pop) begin
        rd_ptr <= (rd_ptr == LastPtr) ? '0 : rd_ptr + 1'b1;
      end
      count <= count + {{PtrW{1'b0}}, push} - {{PtrW{1'b0}}, pop};
    end
  end

  // Count never runs past the depth
  a_no_write_full: assert property (@(posedge clk_i) disable iff (!arst_n_i)
    count <= Full);

  // An empty queue has both pointers on the same slot
  a_no_read_empty: assert property (@(posedge clk_i) disable iff (!arst_n_i)
    (count == '0) |-> (wr_ptr == rd_ptr));

endmodule

// ==== src/copro_top.sv ====
`timescale 1ns/1ps

module copro_top #(
  parameter int FifoDepth = 4
) (
  input  logic                       clk_i,
  input  logic                       arst_n_i,
  // Issue channel
  input  logic                       issue_valid_i,
  output logic                       issue_ready_o,
  input  logic [31:0]                issue_instr_i,
  input  logic [copro_pkg::ID_W-1:0] issue_id_i,
  input  logic [copro_pkg::XLEN-1:0] issue_rs1_i,
  input  logic [copro_pkg::XLEN-1:0] issue_rs2_i,
  output logic                       issue_accept_o,
  // Result channel
  output logic                       result_valid_o,
  input  logic                       result_ready_i,
  output logic [copro_pkg::ID_W-1:0] result_id_o,
  output logic [4:0]                 result_rd_o,
  output logic [copro_pkg::XLEN-1:0] result_data_o,
  // Configuration
  input  logic                       cfg_we_i,
  input  logic [3:0]                 cfg_en_i,
  output logic [3:0]                 cfg_en_o,
  output logic [15:0]                acc_count_o
);

  copro_op_if         op_if ();
  logic               accept;
  logic               exec_valid;
  logic               exec_ready;
  copro_pkg::result_t exec_res;
  copro_pkg::result_t fifo_res;

  copro_cfg_regs i_cfg_regs (
    .clk_i       ( clk_i       ),
    .arst_n_i    ( arst_n_i    ),
    .cfg_we_i    ( cfg_we_i    ),
    .cfg_en_i    ( cfg_en_i    ),
    .accept_i    ( accept      ),
    .op_en_o     ( cfg_en_o    ),
    .acc_count_o ( acc_count_o )
  );

  copro_decoder i_decoder (
    .issue_valid_i  ( issue_valid_i  ),
    .issue_instr_i  ( issue_instr_i  ),
    .issue_id_i     ( issue_id_i     ),
    .issue_rs1_i    ( issue_rs1_i    ),
    .issue_rs2_i    ( issue_rs2_i    ),
    .issue_ready_o  ( issue_ready_o  ),
    .issue_accept_o ( issue_accept_o ),
    .op_en_i        ( cfg_en_o       ),
    .accept_o       ( accept         ),
    .op_if          ( op_if.decoder  )
  );

  copro_exec i_exec (
    .clk_i       ( clk_i       ),
    .arst_n_i    ( arst_n_i    ),
    .op_if       ( op_if.exec  ),
    .res_valid_o ( exec_valid  ),
    .res_ready_i ( exec_ready  ),
    .res_o       ( exec_res    )
  );

  copro_result_fifo #(
    .FifoDepth ( FifoDepth )
  ) i_result_fifo (
    .clk_i       ( clk_i          ),
    .arst_n_i    ( arst_n_i       ),
    .in_valid_i  ( exec_valid     ),
    .in_ready_o  ( exec_ready     ),
    .in_data_i   ( exec_res       ),
    .out_valid_o ( result_valid_o ),
    .out_ready_i ( result_ready_i ),
    .out_data_o  ( fifo_res       )
  );

  // Queue head onto the flat result ports
  assign result_id_o   = fifo_res.id;
  assign result_rd_o   = fifo_res.rd;
  assign result_data_o = fifo_res.data;

endmodule
